//--- run.sh
#!/usr/bin/env bash
# Compile the decode stage and its testbench with Verilator, then run it.
# The exit status is the simulator's, nonzero when any check fails.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module rv_decode_tb -o rv_decode_sim &&
./obj_dir/rv_decode_sim ||
exit 1

//--- source/csr_ctrl_decode.sv
/*
 * SYSTEM decoder: Zicsr read/write controls, CSR address and the
 * ECALL, EBREAK and MRET trap flags
 */
`default_nettype none

`include "rv_decode_macros.svh"

module csr_ctrl_decode (
    input  logic [`INSTR_W-1:0]    instr,
    output logic                   csr_wb,
    output logic                   csr_re,
    output logic                   csr_we,
    output rv_decode_pkg::csr_op_t csr_op,
    output logic                   csr_imm,
    output logic [`CSR_ADDR_W-1:0] csr_addr,
    output logic                   ecall,
    output logic                   ebreak,
    output logic                   mret
);

    import rv_decode_pkg::*;

    logic [2:0]            funct3;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;        // uimm for the I forms
    logic [11:0]           funct12;
    logic                  is_system;

    assign funct3    = instr[14:12];
    assign rd        = instr[11:7];
    assign rs1       = instr[19:15];
    assign funct12   = instr[31:20];
    assign is_system = (instr[6:0] == `OPCODE_SYSTEM);

    always_comb
    begin
        csr_wb   = 1'b0;
        csr_re   = 1'b0;
        csr_we   = 1'b0;
        csr_op   = none;
        csr_imm  = 1'b0;
        csr_addr = '0;
        ecall    = 1'b0;
        ebreak   = 1'b0;
        mret     = 1'b0;

        if (is_system)
        begin
            case (funct3)
                `FUNCT3_PRIV:
                begin
                    csr_re = 1'b1;      // Trap logic reads the target
                    case (funct12)
                        `FUNCT12_ECALL:
                        begin
                            ecall    = 1'b1;
                            csr_addr = `CSR_MTVEC_ADDR;
                        end
                        `FUNCT12_EBREAK:
                        begin
                            ebreak   = 1'b1;
                            csr_addr = `CSR_MTVEC_ADDR;
                        end
                        `FUNCT12_MRET:
                        begin
                            mret     = 1'b1;
                            csr_addr = `CSR_MEPC_ADDR;
                        end
                        default:
                        begin
                            csr_addr = '0;
                        end
                    endcase
                end
                `FUNCT3_CSRRW, `FUNCT3_CSRRWI:
                begin
                    csr_op   = write;
                    csr_we   = 1'b1;
                    csr_re   = (rd != '0);  // No read side effect for rd = x0
                    csr_wb   = (rd != '0);
                    csr_imm  = funct3[2];
                    csr_addr = funct12;
                end
                `FUNCT3_CSRRS, `FUNCT3_CSRRSI, `FUNCT3_CSRRC, `FUNCT3_CSRRCI:
                begin
                    csr_op   = funct3[0] ? clear : set;
                    csr_re   = 1'b1;
                    csr_wb   = 1'b1;
                    csr_we   = (rs1 != '0);
                    csr_imm  = funct3[2];
                    csr_addr = funct12;
                end
                default:
                begin
                    csr_op = none;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/exec_ctrl_decode.sv
/*
 * Execute-side decoder: ALU operation, operand sources, branch and jump,
 * load/store controls and register writeback
 */
`default_nettype none

`include "rv_decode_macros.svh"

module exec_ctrl_decode (
    input  logic [`INSTR_W-1:0]   instr,
    input  logic                  csr_wb,
    output rv_decode_pkg::alu_op_t   alu_op,
    output rv_decode_pkg::op_a_src_t op_a_src,
    output logic                  op_b_imm,
    output logic                  branch,
    output rv_decode_pkg::br_cond_t  br_cond,
    output logic                  jump,
    output logic                  ld_en,
    output logic                  st_en,
    output logic [`MASK_W-1:0]    ldst_mask,
    output logic                  ldst_unsigned,
    output logic                  rf_we,
    output rv_decode_pkg::rf_src_t   rf_src
);

    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // Shared by R and I forms; SUB only exists as a register op
    function automatic alu_op_t alu_fn(
        input logic [2:0] f3,
        input logic       sub_en,
        input logic       sra_en
    );
        case (f3)
            `FUNCT3_ADD:  alu_fn = sub_en ? sub : add;
            `FUNCT3_SLL:  alu_fn = sll;
            `FUNCT3_SLT:  alu_fn = slt;
            `FUNCT3_SLTU: alu_fn = sltu;
            `FUNCT3_XOR:  alu_fn = xor_op;
            `FUNCT3_SRL:  alu_fn = sra_en ? sra : srl;
            `FUNCT3_OR:   alu_fn = or_op;
            default:      alu_fn = and_op;
        endcase
    endfunction

    // Byte lanes from the access size in funct3[1:0]
    function automatic logic [`MASK_W-1:0] size_mask(input logic [1:0] size);
        case (size)
            2'b00:   size_mask = 4'b0001;
            2'b01:   size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    endfunction

    always_comb
    begin
        alu_op        = add;
        op_a_src      = src_reg;
        op_b_imm      = 1'b0;
        branch        = 1'b0;
        br_cond       = eq;
        jump          = 1'b0;
        ld_en         = 1'b0;
        st_en         = 1'b0;
        ldst_mask     = '0;
        ldst_unsigned = 1'b0;
        rf_we         = 1'b0;
        rf_src        = wb_alu;

        case (opcode)
            `OPCODE_R:
            begin
                alu_op = alu_fn(funct3, instr[30], instr[30]);
                rf_we  = 1'b1;
            end
            `OPCODE_I:
            begin
                alu_op   = alu_fn(funct3, 1'b0, instr[30]);    // Bit 30 picks SRAI
                op_b_imm = 1'b1;
                rf_we    = 1'b1;
            end
            `OPCODE_LOAD:
            begin
                op_b_imm      = 1'b1;
                ld_en         = 1'b1;
                ldst_mask     = size_mask(funct3[1:0]);
                ldst_unsigned = funct3[2];                    // LBU, LHU
                rf_we         = 1'b1;
                rf_src        = wb_load;
            end
            `OPCODE_STORE:
            begin
                op_b_imm  = 1'b1;
                st_en     = 1'b1;
                ldst_mask = size_mask(funct3[1:0]);
            end
            `OPCODE_BRANCH:
            begin
                op_a_src = src_pc;
                branch   = 1'b1;
                case (funct3)
                    `FUNCT3_BNE:  br_cond = ne;
                    `FUNCT3_BLT:  br_cond = lt;
                    `FUNCT3_BGE:  br_cond = ge;
                    `FUNCT3_BLTU: br_cond = ltu;
                    `FUNCT3_BGEU: br_cond = geu;
                    default:      br_cond = eq;
                endcase
            end
            `OPCODE_JAL:
            begin
                op_a_src = src_pc;
                jump     = 1'b1;
                rf_we    = 1'b1;
                rf_src   = wb_pc4;
            end
            `OPCODE_JALR:
            begin
                op_b_imm = 1'b1;
                jump     = 1'b1;
                rf_we    = 1'b1;
                rf_src   = wb_pc4;
            end
            `OPCODE_LUI:
            begin
                op_a_src = src_zero;
                op_b_imm = 1'b1;
                rf_we    = 1'b1;
            end
            `OPCODE_AUIPC:
            begin
                op_a_src = src_pc;
                op_b_imm = 1'b1;
                rf_we    = 1'b1;
            end
            default:
            begin
                rf_we = 1'b0;       // FENCE, FENCE.I, SYSTEM, unknown
            end
        endcase

        if (csr_wb)
        begin
            rf_we  = 1'b1;
            rf_src = wb_csr;
        end
    end

endmodule

`default_nettype wire

//--- source/pipe_stage.sv
/*
 * Single-entry valid/ready register slot with a typed payload
 */
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // Open when empty or when the held entry leaves this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            full <= 1'b0;
        end
        else if (in_ready)
        begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

`default_nettype wire

//--- source/rv_decode_macros.svh
/*
 * RV32I and Zicsr decode constants: widths, opcodes, funct3 and funct12
 * encodings, and the machine CSR addresses used by the trap path
 */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

`define XLEN                32
`define INSTR_W             32
`define REG_IDX_W           5
`define MASK_W              4
`define CSR_ADDR_W          12

// Major opcodes, instr[6:0]
`define OPCODE_R            7'b0110011
`define OPCODE_I            7'b0010011
`define OPCODE_LOAD         7'b0000011
`define OPCODE_STORE        7'b0100011
`define OPCODE_BRANCH       7'b1100011
`define OPCODE_JAL          7'b1101111
`define OPCODE_JALR         7'b1100111
`define OPCODE_LUI          7'b0110111
`define OPCODE_AUIPC        7'b0010111
`define OPCODE_FENCE        7'b0001111
`define OPCODE_SYSTEM       7'b1110011

// ALU funct3, shared by R and I forms
`define FUNCT3_ADD          3'b000      // Also SUB
`define FUNCT3_SLL          3'b001
`define FUNCT3_SLT          3'b010
`define FUNCT3_SLTU         3'b011
`define FUNCT3_XOR          3'b100
`define FUNCT3_SRL          3'b101      // Also SRA
`define FUNCT3_OR           3'b110
`define FUNCT3_AND          3'b111

// Load and store widths
`define FUNCT3_LB           3'b000
`define FUNCT3_LH           3'b001
`define FUNCT3_LW           3'b010
`define FUNCT3_LBU          3'b100
`define FUNCT3_LHU          3'b101
`define FUNCT3_SB           3'b000
`define FUNCT3_SH           3'b001
`define FUNCT3_SW           3'b010

`define FUNCT3_BEQ          3'b000
`define FUNCT3_BNE          3'b001
`define FUNCT3_BLT          3'b100
`define FUNCT3_BGE          3'b101
`define FUNCT3_BLTU         3'b110
`define FUNCT3_BGEU         3'b111

`define FUNCT3_FENCE        3'b000
`define FUNCT3_FENCE_I      3'b001

`define FUNCT3_PRIV         3'b000      // ECALL, EBREAK, MRET
`define FUNCT3_CSRRW        3'b001
`define FUNCT3_CSRRS        3'b010
`define FUNCT3_CSRRC        3'b011
`define FUNCT3_CSRRWI       3'b101
`define FUNCT3_CSRRSI       3'b110
`define FUNCT3_CSRRCI       3'b111

`define FUNCT12_ECALL       12'h000
`define FUNCT12_EBREAK      12'h001
`define FUNCT12_MRET        12'h302

`define CSR_MTVEC_ADDR      12'h305
`define CSR_MEPC_ADDR       12'h341

`endif

//--- source/rv_decode_pkg.sv
/*
 * Decode types: ALU operation, branch condition, operand A source,
 * writeback source, CSR operation and the full control word
 */
`default_nettype none

`include "rv_decode_macros.svh"

package rv_decode_pkg;

    typedef enum logic [3:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op
    } alu_op_t;

    typedef enum logic [2:0] {
        eq,
        ne,
        lt,
        ge,
        ltu,
        geu
    } br_cond_t;

    typedef enum logic [1:0] {
        src_reg,
        src_pc,
        src_zero
    } op_a_src_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4,
        wb_csr
    } rf_src_t;

    typedef enum logic [1:0] {
        none,
        write,
        set,
        clear
    } csr_op_t;

    typedef struct packed {
        alu_op_t                alu_op;
        op_a_src_t              op_a_src;
        logic                   op_b_imm;
        logic                   branch;
        br_cond_t               br_cond;
        logic                   jump;
        logic                   ld_en;
        logic                   st_en;
        logic [`MASK_W-1:0]     ldst_mask;
        logic                   ldst_unsigned;
        logic                   rf_we;
        rf_src_t                rf_src;
        logic                   csr_wb;       // rd takes the CSR value
        logic                   csr_re;
        logic                   csr_we;
        csr_op_t                csr_op;
        logic                   csr_imm;
        logic [`CSR_ADDR_W-1:0] csr_addr;
        logic                   ecall;
        logic                   ebreak;
        logic                   mret;
    } ctrl_word_t;

endpackage

`default_nettype wire

//--- source/rv_decode_top.sv
/*
 * Decode stage top: instruction register, execute and CSR decoders,
 * control word register
 */
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`INSTR_W-1:0]      instr,
    output logic                     out_valid,
    input  logic                     out_ready,
    output rv_decode_pkg::alu_op_t   alu_op,
    output rv_decode_pkg::op_a_src_t op_a_src,
    output logic                     op_b_imm,
    output logic                     branch,
    output rv_decode_pkg::br_cond_t  br_cond,
    output logic                     jump,
    output logic                     ld_en,
    output logic                     st_en,
    output logic [`MASK_W-1:0]       ldst_mask,
    output logic                     ldst_unsigned,
    output logic                     rf_we,
    output rv_decode_pkg::rf_src_t   rf_src,
    output logic                     csr_wb,
    output logic                     csr_re,
    output logic                     csr_we,
    output rv_decode_pkg::csr_op_t   csr_op,
    output logic                     csr_imm,
    output logic [`CSR_ADDR_W-1:0]   csr_addr,
    output logic                     ecall,
    output logic                     ebreak,
    output logic                     mret
);

    import rv_decode_pkg::*;

    logic [`INSTR_W-1:0] instr_q;
    logic                instr_valid;
    logic                instr_ready;
    ctrl_word_t          ctrl_d;
    ctrl_word_t          ctrl_q;

    pipe_stage #(.payload_t(logic [`INSTR_W-1:0])) instr_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (instr),
        .out_valid (instr_valid),
        .out_ready (instr_ready),
        .out_data  (instr_q)
    );

    exec_ctrl_decode exec_ctrl_decode_i (
        .instr         (instr_q),
        .csr_wb        (ctrl_d.csr_wb),
        .alu_op        (ctrl_d.alu_op),
        .op_a_src      (ctrl_d.op_a_src),
        .op_b_imm      (ctrl_d.op_b_imm),
        .branch        (ctrl_d.branch),
        .br_cond       (ctrl_d.br_cond),
        .jump          (ctrl_d.jump),
        .ld_en         (ctrl_d.ld_en),
        .st_en         (ctrl_d.st_en),
        .ldst_mask     (ctrl_d.ldst_mask),
        .ldst_unsigned (ctrl_d.ldst_unsigned),
        .rf_we         (ctrl_d.rf_we),
        .rf_src        (ctrl_d.rf_src)
    );

    csr_ctrl_decode csr_ctrl_decode_i (
        .instr    (instr_q),
        .csr_wb   (ctrl_d.csr_wb),
        .csr_re   (ctrl_d.csr_re),
        .csr_we   (ctrl_d.csr_we),
        .csr_op   (ctrl_d.csr_op),
        .csr_imm  (ctrl_d.csr_imm),
        .csr_addr (ctrl_d.csr_addr),
        .ecall    (ctrl_d.ecall),
        .ebreak   (ctrl_d.ebreak),
        .mret     (ctrl_d.mret)
    );

    pipe_stage #(.payload_t(ctrl_word_t)) ctrl_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (instr_valid),
        .in_ready  (instr_ready),
        .in_data   (ctrl_d),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (ctrl_q)
    );

    // Field order follows ctrl_word_t
    assign {alu_op, op_a_src, op_b_imm, branch, br_cond, jump, ld_en, st_en,
            ldst_mask, ldst_unsigned, rf_we, rf_src, csr_wb, csr_re, csr_we,
            csr_op, csr_imm, csr_addr, ecall, ebreak, mret} = ctrl_q;

endmodule

`default_nettype wire

//--- tb/rv_decode_properties.sv
/*
 * Handshake properties of the decode stage: output hold under stall,
 * reset state and input blocking, bound into rv_decode_top
 */
`default_nettype none

module rv_decode_properties (
    input logic                      clk,
    input logic                      reset,
    input logic                      in_ready,
    input logic                      out_valid,
    input logic                      out_ready,
    input rv_decode_pkg::ctrl_word_t ctrl
);

    timeunit 1ns;
    timeprecision 100ps;

    // Stalled output keeps its valid
    out_hold_valid: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped while out_ready was low");

    // Stalled output keeps its control word
    out_hold_data: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(ctrl))
        else $error("control outputs changed while out_ready was low");

    reset_empty: assert property (@(posedge clk)
        reset |=> !out_valid)
        else $error("out_valid high after a reset edge");

    // Both stages full is the only way to block the input
    in_block_when_full: assert property (@(posedge clk) disable iff (reset)
        !in_ready |-> out_valid && !out_ready)
        else $error("in_ready low while the output stage could move");

endmodule

bind rv_decode_top rv_decode_properties rv_decode_properties_i (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .ctrl      (ctrl_q)
);

`default_nettype wire

//--- tb/rv_decode_tb.sv
/*
 * Testbench for the decode stage: clock, reset, random instruction stream,
 * reference decode model, output checks and watchdog
 */
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_decode_pkg::*;

    localparam int clk_period = 40;
    localparam int n_random   = 300;
    localparam int n_stream   = 40;

    localparam alu_op_t  alu_by_f3 [8] = '{add, sll, slt, sltu, xor_op, srl, or_op, and_op};
    localparam br_cond_t br_by_f3 [8]  = '{eq, ne, eq, eq, lt, ge, ltu, geu};
    localparam logic [2:0]  load_f3 [5]   = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    localparam logic [2:0]  store_f3 [3]  = '{3'b000, 3'b001, 3'b010};
    localparam logic [2:0]  branch_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    localparam logic [2:0]  csr_f3 [6]    = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
    localparam logic [11:0] priv_f12 [4]  = '{`FUNCT12_ECALL, `FUNCT12_EBREAK, `FUNCT12_MRET,
                                             12'h105};    // WFI sets no flag

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic                in_ready;
    logic [`INSTR_W-1:0] instr;
    logic                out_valid;
    logic                out_ready;
    ctrl_word_t          dut_ctrl;

    string      cur_name;
    bit         stream_mode;
    int         cyc;
    int         in_count;
    int         out_count;
    ctrl_word_t exp_q[$];
    string      name_q[$];
    int         acc_q[$];
    bit         stream_q[$];
    ctrl_word_t exp_word;
    string      exp_name;
    int         acc_cyc;
    bit         was_stream;

    rv_decode_top rv_decode_top_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .instr         (instr),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .alu_op        (dut_ctrl.alu_op),
        .op_a_src      (dut_ctrl.op_a_src),
        .op_b_imm      (dut_ctrl.op_b_imm),
        .branch        (dut_ctrl.branch),
        .br_cond       (dut_ctrl.br_cond),
        .jump          (dut_ctrl.jump),
        .ld_en         (dut_ctrl.ld_en),
        .st_en         (dut_ctrl.st_en),
        .ldst_mask     (dut_ctrl.ldst_mask),
        .ldst_unsigned (dut_ctrl.ldst_unsigned),
        .rf_we         (dut_ctrl.rf_we),
        .rf_src        (dut_ctrl.rf_src),
        .csr_wb        (dut_ctrl.csr_wb),
        .csr_re        (dut_ctrl.csr_re),
        .csr_we        (dut_ctrl.csr_we),
        .csr_op        (dut_ctrl.csr_op),
        .csr_imm       (dut_ctrl.csr_imm),
        .csr_addr      (dut_ctrl.csr_addr),
        .ecall         (dut_ctrl.ecall),
        .ebreak        (dut_ctrl.ebreak),
        .mret          (dut_ctrl.mret)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic finish_failed();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string what);
        $display("error: %s", what);
        finish_failed();
    endtask

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("mismatch %s expected %h actual %h", test, expected, actual);
        finish_failed();
    endtask

    // x0 about a quarter of the time
    function automatic logic [4:0] pick_reg();
        pick_reg = ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
    endfunction

    // Reference decode of one instruction
    function automatic ctrl_word_t expected_ctrl(input logic [`INSTR_W-1:0] ins);
        ctrl_word_t  c;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [11:0] f12;
        opc        = ins[6:0];
        f3         = ins[14:12];
        f12        = ins[31:20];
        c          = '0;
        c.alu_op   = add;
        c.op_a_src = src_reg;
        c.br_cond  = eq;
        c.rf_src   = wb_alu;
        c.csr_op   = none;
        if (opc == `OPCODE_R || opc == `OPCODE_I)
        begin
            c.alu_op = alu_by_f3[f3];
            if (opc == `OPCODE_R && f3 == `FUNCT3_ADD && ins[30])
                c.alu_op = sub;
            if (f3 == `FUNCT3_SRL && ins[30])
                c.alu_op = sra;
            c.op_b_imm = (opc == `OPCODE_I);
            c.rf_we    = 1'b1;
        end
        if (opc == `OPCODE_LOAD || opc == `OPCODE_STORE)
        begin
            c.ldst_mask = (f3[1:0] == 2'b00) ? 4'b0001 : (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
            c.op_b_imm      = 1'b1;
            c.ld_en         = (opc == `OPCODE_LOAD);
            c.st_en         = !c.ld_en;
            c.ldst_unsigned = c.ld_en && f3[2];
            c.rf_we         = c.ld_en;
            c.rf_src        = c.ld_en ? wb_load : wb_alu;
        end
        if (opc == `OPCODE_BRANCH)
        begin
            c.branch   = 1'b1;
            c.op_a_src = src_pc;
            c.br_cond  = br_by_f3[f3];
        end
        if (opc == `OPCODE_JAL || opc == `OPCODE_JALR)
        begin
            c.jump     = 1'b1;
            c.rf_we    = 1'b1;
            c.rf_src   = wb_pc4;
            c.op_a_src = (opc == `OPCODE_JAL) ? src_pc : src_reg;
            c.op_b_imm = (opc == `OPCODE_JALR);
        end
        if (opc == `OPCODE_LUI || opc == `OPCODE_AUIPC)
        begin
            c.rf_we    = 1'b1;
            c.op_b_imm = 1'b1;
            c.op_a_src = (opc == `OPCODE_LUI) ? src_zero : src_pc;
        end
        if (opc == `OPCODE_SYSTEM)
        begin
            if (f3 == `FUNCT3_PRIV)
            begin
                c.csr_re = 1'b1;
                c.ecall  = (f12 == `FUNCT12_ECALL);
                c.ebreak = (f12 == `FUNCT12_EBREAK);
                c.mret   = (f12 == `FUNCT12_MRET);
                if (c.ecall || c.ebreak)
                    c.csr_addr = `CSR_MTVEC_ADDR;
                else if (c.mret)
                    c.csr_addr = `CSR_MEPC_ADDR;
            end
            else if (f3 != 3'b100)
            begin
                c.csr_addr = f12;
                c.csr_imm  = f3[2];
                if (f3[1:0] == 2'b01)
                begin
                    c.csr_op = write;
                    c.csr_we = 1'b1;
                    c.csr_wb = (ins[11:7] != 5'd0);
                end
                else
                begin
                    c.csr_op = (f3[1:0] == 2'b10) ? set : clear;
                    c.csr_we = (ins[19:15] != 5'd0);
                    c.csr_wb = 1'b1;
                end
                c.csr_re = c.csr_wb;
            end
            if (c.csr_wb)
            begin
                c.rf_we  = 1'b1;
                c.rf_src = wb_csr;
            end
        end
        return c;
    endfunction

    task automatic make_instr(output logic [`INSTR_W-1:0] ins, output string name);
        int         kind;
        logic [2:0] idx;
        kind       = $urandom_range(99);
        idx        = 3'($urandom_range(5));
        ins        = $urandom;
        ins[11:7]  = pick_reg();
        ins[19:15] = pick_reg();
        if (kind < 28)
        begin
            ins[6:0] = (kind < 14) ? `OPCODE_R : `OPCODE_I;
            name     = (kind < 14) ? "r_type" : "i_type";
            if (kind < 14 || ins[14:12] == `FUNCT3_SLL || ins[14:12] == `FUNCT3_SRL)
            begin
                // Top random bit picks SUB or SRA where the encoding allows it
                if ((ins[14:12] == `FUNCT3_ADD && kind < 14) || ins[14:12] == `FUNCT3_SRL)
                    ins[31:25] = ins[31] ? 7'b0100000 : 7'b0000000;
                else
                    ins[31:25] = 7'b0000000;
            end
        end
        else if (kind < 36)
        begin
            ins[6:0]   = `OPCODE_LOAD;
            ins[14:12] = load_f3[idx % 5];
            name       = "load";
        end
        else if (kind < 44)
        begin
            ins[6:0]   = `OPCODE_STORE;
            ins[14:12] = store_f3[idx % 3];
            name       = "store";
        end
        else if (kind < 54)
        begin
            ins[6:0]   = `OPCODE_BRANCH;
            ins[14:12] = branch_f3[idx];
            name       = "branch";
        end
        else if (kind < 70)
        begin
            ins[6:0] = (kind < 58) ? `OPCODE_JAL : (kind < 62) ? `OPCODE_JALR :
                       (kind < 66) ? `OPCODE_LUI : `OPCODE_AUIPC;
            if (ins[6:0] == `OPCODE_JALR)
                ins[14:12] = 3'b000;
            name = "jump_upper";
        end
        else if (kind < 74)
        begin
            ins[6:0]   = `OPCODE_FENCE;
            ins[14:12] = {2'b00, idx[0]};
            name       = "fence";
        end
        else if (kind < 90)
        begin
            ins[6:0]   = `OPCODE_SYSTEM;
            ins[14:12] = csr_f3[idx];
            name       = "csr";
        end
        else
        begin
            ins[6:0]   = `OPCODE_SYSTEM;
            ins[14:12] = `FUNCT3_PRIV;
            ins[11:7]  = 5'd0;
            ins[19:15] = 5'd0;
            ins[31:20] = priv_f12[idx[1:0]];
            name       = "priv";
        end
        name = $sformatf("%s %h", name, ins);
    endtask

    // One cycle per loop pass; inputs change 2 ns after the edge
    task automatic run_phase(input int count, input int valid_pct, input int ready_pct,
                             input bit stream);
        int sent;
        int stall;
        bit took;
        sent        = 0;
        stall       = 0;
        took        = 1'b0;
        stream_mode = stream;
        while (sent < count)
        begin
            @(posedge clk);
            #2;
            if (in_valid && took)
            begin
                sent++;
                in_valid = 1'b0;
            end
            if (!in_valid && sent < count && $urandom_range(99) < valid_pct)
            begin
                make_instr(instr, cur_name);
                in_valid = 1'b1;
            end
            if (stream)
                out_ready = 1'b1;
            else if (stall > 0)
            begin
                out_ready = 1'b0;
                stall--;
            end
            else if ($urandom_range(99) < 4)
            begin
                stall     = $urandom_range(12, 5);    // Long back-pressure burst
                out_ready = 1'b0;
            end
            else
                out_ready = ($urandom_range(99) < ready_pct);
            #1;
            took = in_ready;
        end
        stream_mode = 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        #2;
        out_ready = 1'b1;
        while (exp_q.size() != 0)
            @(posedge clk);
    endtask

    // Mid-cycle sampling; a handshake seen here completes at the next edge
    always @(negedge clk)
    begin
        if (!reset)
        begin
            cyc++;
            if (stream_mode)
                assert (in_ready) else stop_with_error("in_ready fell while streaming");
            if (out_valid && out_ready)
            begin
                out_count++;
                if (exp_q.size() == 0)
                    stop_with_error("output transfer with no instruction outstanding");
                else
                begin
                    exp_word   = exp_q.pop_front();
                    exp_name   = name_q.pop_front();
                    acc_cyc    = acc_q.pop_front();
                    was_stream = stream_q.pop_front();
                    assert (dut_ctrl == exp_word)
                        else report_mismatch(exp_name, 64'(exp_word), 64'(dut_ctrl));
                    if (was_stream)
                        assert (cyc - acc_cyc == 2)
                            else report_mismatch({exp_name, " latency"}, 64'(2),
                                                 64'(cyc - acc_cyc));
                end
            end
            if (in_valid && in_ready)
            begin
                in_count++;
                exp_q.push_back(expected_ctrl(instr));
                name_q.push_back(cur_name);
                acc_q.push_back(cyc);
                stream_q.push_back(stream_mode);
            end
        end
    end

    initial
    begin
        #((n_random + n_stream) * 6 * clk_period + 100 * clk_period);
        stop_with_error("watchdog expired before all instructions drained");
    end

    initial
    begin
        void'($urandom(98934));
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        instr       = '0;
        out_ready   = 1'b0;
        stream_mode = 1'b0;
        cur_name    = "";
        cyc         = 0;
        in_count    = 0;
        out_count   = 0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        run_phase(n_random, 70, 70, 1'b0);
        drain();
        run_phase(n_stream, 100, 100, 1'b1);
        drain();
        repeat (3) @(posedge clk);
        if (in_count == out_count && in_count == n_random + n_stream)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
            stop_with_error($sformatf("%0d instructions in, %0d out", in_count, out_count));
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/rv_decode_pkg.sv
source/pipe_stage.sv
source/exec_ctrl_decode.sv
source/csr_ctrl_decode.sv
source/rv_decode_top.sv
tb/rv_decode_properties.sv
tb/rv_decode_tb.sv
